/* list.f */
source/usb_phy_pkg.sv
source/tx_bit_if.sv
source/utmi_tx_serializer.sv
source/nrzi_line_driver.sv
source/utmi_rx_deserializer.sv
source/usb_phy_top.sv
test/usb_phy_tb.sv

/* Makefile */
# Verilator build and run of the USB full-speed PHY testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module usb_phy_tb -f list.f -o usb_phy_sim
	@out="$$(./obj_dir/usb_phy_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

/* test/usb_phy_tb.sv */
// Testbench for usb_phy_top that checks random packets on the line, in loopback and from the line
`timescale 1ns/10ps

module usb_phy_tb;

    localparam int TX_PACKETS = 20;
    localparam int RX_PACKETS = 20;
    // 40 packets of up to 8 bytes at 10 bit times, plus SYNC, EOP, gaps and a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                     clk;
    logic                     rst_n;
    logic [7:0]               data_out;
    logic                     tx_valid;
    logic                     tx_ready;
    logic [7:0]               data_in;
    logic                     rx_valid;
    logic                     rx_active;
    logic                     rx_error;
    logic [1:0]               op_mode;
    logic                     suspend_m;
    usb_phy_pkg::line_state_e line_state;
    logic                     dp_o;
    logic                     dm_o;
    logic                     line_oe;
    logic                     dp_i;
    logic                     dm_i;
    logic                     enc_dp;   // Testbench encoder drives the bus while line_oe is low
    logic                     enc_dm;

    logic [7:0] pkt_q[$];    // Packet under test
    logic [1:0] line_q[$];   // Reference line symbols as {dp, dm}
    logic [1:0] cap_q[$];    // Symbols seen while the DUT drives
    logic [7:0] rx_q[$];     // Bytes delivered on data_in
    int rx_errors = 0;
    int err_at = 0;          // Bytes received before the latest rx_error
    int active_cycles = 0;
    int ready_pulses = 0;    // Cycles with tx_ready high
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    usb_phy_top dut (.*);

    // Resolved bus
    assign dp_i = line_oe ? dp_o : enc_dp;
    assign dm_i = line_oe ? dm_o : enc_dm;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run was still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Line and UTMI monitor sampled mid-cycle
    always @(negedge clk) begin
        if (line_oe)
            cap_q.push_back({dp_o, dm_o});
        if (rx_valid)
            rx_q.push_back(data_in);
        if (rx_error) begin
            rx_errors++;
            err_at = rx_q.size();
        end
        if (rx_active)
            active_cycles++;
        if (tx_ready)
            ready_pulses++;
    end

    task automatic report_mismatch(input string test, input string what, input int expected,
                                   input int actual);
        $display("error %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
        errors++;
    endtask

    task automatic finish_test(input string test, input int fails);
        if (fails == 0) begin
            $display("test %-12s passed", test);
            tests_passed++;
        end else begin
            $display("test %-12s failed with %0d errors", test, fails);
            tests_failed++;
        end
    endtask

    task automatic make_packet(input int n);
        pkt_q.delete();
        for (int i = 0; i < n; i++)
            pkt_q.push_back(($urandom_range(0, 3) == 0) ? 8'hFF : 8'($urandom));  // FF forces stuffing
    endtask

    // Reference encoder for SYNC and data LSB first with bit stuffing, NRZI and SE0 SE0 J
    task automatic encode_line(input int nbits, input bit stuff_on);
        logic [1:0] lvl;
        logic [7:0] cur;
        int         ones;
        bit         b;
        line_q.delete();
        lvl = usb_phy_pkg::LS_J;
        ones = 0;
        for (int i = 0; i < 8 + nbits; i++) begin
            if (i < 8)
                cur = usb_phy_pkg::SYNC_BYTE;
            else
                cur = pkt_q[(i - 8) / 8];
            b = cur[3'(i % 8)];
            if (!b)
                lvl = ~lvl;  // Zero toggles between J and K
            line_q.push_back(lvl);
            ones = b ? ones + 1 : 0;
            if (stuff_on && ones == usb_phy_pkg::STUFF_RUN) begin
                lvl = ~lvl;
                line_q.push_back(lvl);
                ones = 0;
            end
        end
        line_q.push_back(usb_phy_pkg::LS_SE0);
        line_q.push_back(usb_phy_pkg::LS_SE0);
        line_q.push_back(usb_phy_pkg::LS_J);
    endtask

    task automatic drive_line();
        foreach (line_q[i]) begin
            @(negedge clk);
            {enc_dp, enc_dm} = line_q[i];
        end
        @(negedge clk);
        {enc_dp, enc_dm} = usb_phy_pkg::LS_J;
    endtask

    // Host side of the transmit handshake
    task automatic send_packet();
        int taken;
        taken = 0;
        data_out = pkt_q[0];
        tx_valid = 1'b1;
        while (taken <= pkt_q.size()) begin
            @(negedge clk);
            if (tx_ready) begin
                @(negedge clk);  // Byte went in at the edge in between
                taken++;
                if (taken < pkt_q.size())
                    data_out = pkt_q[taken];
                else
                    tx_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (rx_active || line_oe)
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic check_bytes(input string test, input int base, input int count);
        if (rx_q.size() - base != count) begin
            report_mismatch(test, "byte count", count, rx_q.size() - base);
        end else begin
            for (int i = 0; i < count; i++) begin
                if (rx_q[base + i] !== pkt_q[i])
                    report_mismatch(test, $sformatf("byte %0d", i), int'(pkt_q[i]),
                                    int'(rx_q[base + i]));
            end
        end
    endtask

    task automatic check_line(input int base);
        if (cap_q.size() - base != line_q.size()) begin
            report_mismatch("tx_encoding", "line symbols", line_q.size(), cap_q.size() - base);
        end else begin
            for (int i = 0; i < line_q.size(); i++) begin
                if (cap_q[base + i] !== line_q[i]) begin
                    report_mismatch("tx_encoding", $sformatf("symbol %0d", i), int'(line_q[i]),
                                    int'(cap_q[base + i]));
                    break;
                end
            end
        end
    endtask

    initial begin
        int n;
        int e0;
        int base;
        int cap_base;
        int err_base;
        int ready_base;
        int tx_fail;
        int lb_fail;
        int bad;
        void'($urandom(45));
        rst_n = 1'b0;
        data_out = 8'h00;
        tx_valid = 1'b0;
        op_mode = usb_phy_pkg::OPMODE_NORMAL;
        suspend_m = 1'b1;
        {enc_dp, enc_dm} = usb_phy_pkg::LS_J;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        if ({tx_ready, line_oe, rx_active, rx_valid, rx_error, dp_o, dm_o} !== 7'b0000010)
            report_mismatch("reset", "tx_ready,line_oe,rx_active,rx_valid,rx_error,dp_o,dm_o",
                            2, int'({tx_ready, line_oe, rx_active, rx_valid, rx_error, dp_o, dm_o}));
        if (data_in !== 8'h00)
            report_mismatch("reset", "data_in", 0, int'(data_in));
        repeat (2) @(negedge clk);
        if (line_state !== usb_phy_pkg::LS_J)
            report_mismatch("reset", "line_state", int'(usb_phy_pkg::LS_J), int'(line_state));
        finish_test("reset", errors - e0);

        tx_fail = 0;
        lb_fail = 0;
        for (int p = 0; p < TX_PACKETS; p++) begin
            n = $urandom_range(1, 8);
            make_packet(n);
            encode_line(8 * n, 1'b1);
            cap_base = cap_q.size();
            base = rx_q.size();
            err_base = rx_errors;
            ready_base = ready_pulses;
            send_packet();
            wait_idle();
            e0 = errors;
            if (ready_pulses - ready_base != n + 1)
                report_mismatch("tx_encoding", "tx_ready pulses", n + 1,
                                ready_pulses - ready_base);  // SYNC too
            check_line(cap_base);
            tx_fail += errors - e0;
            e0 = errors;
            check_bytes("loopback", base, n);
            if (rx_errors != err_base)
                report_mismatch("loopback", "rx_error pulses", 0, rx_errors - err_base);
            lb_fail += errors - e0;
        end
        finish_test("tx_encoding", tx_fail);
        finish_test("loopback", lb_fail);

        e0 = errors;
        for (int p = 0; p < RX_PACKETS; p++) begin
            n = $urandom_range(1, 8);
            make_packet(n);
            encode_line(8 * n, 1'b1);
            base = rx_q.size();
            err_base = rx_errors;
            drive_line();
            wait_idle();
            check_bytes("rx_external", base, n);
            if (rx_errors != err_base)
                report_mismatch("rx_external", "rx_error pulses", 0, rx_errors - err_base);
        end
        finish_test("rx_external", errors - e0);

        // Seven ones without a stuffed zero inside the second byte
        e0 = errors;
        pkt_q = '{8'hA5, 8'hFF, 8'hFF};
        encode_line(24, 1'b0);
        base = rx_q.size();
        err_base = rx_errors;
        drive_line();
        wait_idle();
        if (rx_errors - err_base != 1)
            report_mismatch("rx_errors", "stuff error pulses", 1, rx_errors - err_base);
        check_bytes("rx_errors", base, 1);
        if (err_at != base + 1)
            report_mismatch("rx_errors", "bytes before stuff error", 1, err_at - base);
        // EOP after 12 data bits
        make_packet(2);
        encode_line(12, 1'b1);
        base = rx_q.size();
        err_base = rx_errors;
        drive_line();
        wait_idle();
        if (rx_errors - err_base != 1)
            report_mismatch("rx_errors", "short EOP error pulses", 1, rx_errors - err_base);
        check_bytes("rx_errors", base, 1);
        finish_test("rx_errors", errors - e0);

        e0 = errors;
        bad = 0;
        data_out = 8'h3C;
        tx_valid = 1'b1;
        suspend_m = 1'b0;
        for (int i = 0; i < 80; i++) begin
            if (i == 40) begin
                suspend_m = 1'b1;
                op_mode = usb_phy_pkg::OPMODE_NON_DRIVING;
            end
            @(negedge clk);
            if (tx_ready || line_oe)
                bad++;
        end
        if (bad != 0)
            report_mismatch("suspend", "cycles with tx_ready or line_oe", 0, bad);
        tx_valid = 1'b0;
        op_mode = usb_phy_pkg::OPMODE_NORMAL;
        suspend_m = 1'b0;
        make_packet(3);
        encode_line(24, 1'b1);
        base = rx_q.size();
        bad = active_cycles;
        drive_line();
        repeat (6) @(negedge clk);
        if (active_cycles != bad)
            report_mismatch("suspend", "cycles with rx_active", 0, active_cycles - bad);
        if (rx_q.size() != base)
            report_mismatch("suspend", "bytes received", 0, rx_q.size() - base);
        suspend_m = 1'b1;
        repeat (4) @(negedge clk);
        finish_test("suspend", errors - e0);

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* source/usb_phy_top.sv */
// Full-speed USB PHY top level: UTMI byte side and split D+/D- pad signals for the chip-level pad
`timescale 1ns/10ps

module usb_phy_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // UTMI transmit
    input  logic [7:0]               data_out,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    // UTMI receive
    output logic [7:0]               data_in,
    output logic                     rx_valid,
    output logic                     rx_active,
    output logic                     rx_error,
    // Mode and status
    input  logic [1:0]               op_mode,
    input  logic                     suspend_m,
    output usb_phy_pkg::line_state_e line_state,
    // Pad side
    output logic                     dp_o,
    output logic                     dm_o,
    output logic                     line_oe,
    input  logic                     dp_i,
    input  logic                     dm_i
);

    tx_bit_if tx_bits ();

    utmi_tx_serializer u_tx_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_out  (data_out),
        .tx_valid  (tx_valid),
        .suspend_m (suspend_m),
        .op_mode   (op_mode),
        .tx_ready  (tx_ready),
        .bits      (tx_bits.serializer)
    );

    nrzi_line_driver u_line_driver (
        .clk     (clk),
        .rst_n   (rst_n),
        .bits    (tx_bits.driver),
        .dp_o    (dp_o),
        .dm_o    (dm_o),
        .line_oe (line_oe)
    );

    // Receiver sees the resolved bus, own transmissions included
    utmi_rx_deserializer u_rx_deserializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .dp_i       (dp_i),
        .dm_i       (dm_i),
        .suspend_m  (suspend_m),
        .line_state (line_state),
        .data_in    (data_in),
        .rx_valid   (rx_valid),
        .rx_active  (rx_active),
        .rx_error   (rx_error)
    );

endmodule

/* source/utmi_rx_deserializer.sv */
// UTMI receive side: synchronises D+/D-, finds SYNC, NRZI decodes, unstuffs and delivers bytes
`timescale 1ns/10ps

module utmi_rx_deserializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dp_i,
    input  logic                     dm_i,
    input  logic                     suspend_m,
    output usb_phy_pkg::line_state_e line_state,
    output logic [7:0]               data_in,
    output logic                     rx_valid,
    output logic                     rx_active,
    output logic                     rx_error
);

    // One-hot states
    localparam logic [4:0] RX_IDLE = 5'b00001;
    localparam logic [4:0] RX_SYNC = 5'b00010;  // Hunting for the closing KK
    localparam logic [4:0] RX_DATA = 5'b00100;
    localparam logic [4:0] RX_ERR  = 5'b01000;  // Discard until SE0
    localparam logic [4:0] RX_EOP  = 5'b10000;  // Wait for J after SE0

    logic [1:0]               meta_pair;
    logic [1:0]               sync_pair;
    usb_phy_pkg::line_state_e prev_state;
    logic [4:0]               state;
    logic [7:0]               shift_reg;
    logic [2:0]               bit_cnt;
    logic [2:0]               ones_cnt;
    logic                     rx_bit;
    logic                     is_se0;
    logic                     stuffed_slot;
    logic [7:0]               next_byte;

    // Two-flop synchroniser, resets to idle J
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_pair  <= 2'b10;
            sync_pair  <= 2'b10;
            prev_state <= usb_phy_pkg::LS_J;
        end else begin
            meta_pair  <= {dp_i, dm_i};
            sync_pair  <= meta_pair;
            prev_state <= line_state;
        end
    end

    assign line_state = usb_phy_pkg::line_state_e'(sync_pair);

    assign is_se0       = (line_state == usb_phy_pkg::LS_SE0);
    assign rx_bit       = (line_state == prev_state);  // No transition decodes as one
    assign stuffed_slot = (ones_cnt == 3'(usb_phy_pkg::STUFF_RUN));
    assign next_byte    = {rx_bit, shift_reg[7:1]};    // LSB arrives first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= 3'd0;
            ones_cnt  <= 3'd0;
            rx_active <= 1'b0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
            data_in   <= 8'd0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            if (!suspend_m) begin
                state     <= RX_IDLE;
                rx_active <= 1'b0;
            end else begin
                case (1'b1)
                    state[0]: begin
                        if (line_state == usb_phy_pkg::LS_K) begin
                            state     <= RX_SYNC;
                            rx_active <= 1'b1;
                        end
                    end
                    state[1]: begin
                        if (is_se0) begin
                            state <= RX_EOP;
                        end else if (line_state == usb_phy_pkg::LS_K &&
                                     prev_state == usb_phy_pkg::LS_K) begin
                            state    <= RX_DATA;
                            bit_cnt  <= 3'd0;
                            ones_cnt <= 3'd1;  // Final SYNC bit is a one
                        end
                    end
                    state[2]: begin
                        if (is_se0) begin
                            state <= RX_EOP;
                            if (bit_cnt != 3'd0)
                                rx_error <= 1'b1;  // EOP cut a byte short
                        end else if (line_state == usb_phy_pkg::LS_SE1) begin
                            state    <= RX_ERR;
                            rx_error <= 1'b1;
                        end else if (stuffed_slot) begin
                            if (rx_bit) begin
                                state    <= RX_ERR;  // Seventh one in a row
                                rx_error <= 1'b1;
                            end else begin
                                ones_cnt <= 3'd0;    // Drop the stuffed zero
                            end
                        end else begin
                            ones_cnt <= rx_bit ? ones_cnt + 3'd1 : 3'd0;
                            bit_cnt  <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                rx_valid <= 1'b1;
                                data_in  <= next_byte;
                            end
                        end
                    end
                    state[3]: begin
                        if (is_se0)
                            state <= RX_EOP;
                    end
                    state[4]: begin
                        if (line_state == usb_phy_pkg::LS_J) begin
                            state     <= RX_IDLE;
                            rx_active <= 1'b0;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // Byte assembly, data bits only
    always_ff @(posedge clk) begin
        if (state[2] && !is_se0 && !stuffed_slot)
            shift_reg <= next_byte;
    end

    a_valid_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> rx_active);

endmodule

/* source/nrzi_line_driver.sv */
// Full-speed line driver inside usb_phy_top that NRZI codes the bit stream, adds the EOP and sets the output enable
`timescale 1ns/10ps

module nrzi_line_driver (
    input  logic     clk,
    input  logic     rst_n,
    tx_bit_if.driver bits,
    output logic     dp_o,
    output logic     dm_o,
    output logic     line_oe
);

    logic       level;       // Current differential level where 1 is J
    logic [1:0] eop_cnt;     // SE0, SE0, J, then release
    logic       next_level;

    // A zero toggles the line for NRZI and a one holds it
    assign next_level = bits.bit_data ? level : ~level;

    assign bits.eop_done = (eop_cnt == 2'd3);  // J is on the line this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level   <= 1'b1;
            eop_cnt <= 2'd0;
            dp_o    <= 1'b1;
            dm_o    <= 1'b0;
            line_oe <= 1'b0;
        end else if (bits.bit_active && !bits.bit_eop) begin
            level   <= next_level;
            dp_o    <= next_level;
            dm_o    <= ~next_level;
            line_oe <= 1'b1;
        end else if (bits.bit_active) begin
            eop_cnt <= eop_cnt + 2'd1;
            case (eop_cnt)
                2'd0, 2'd1: begin  // Two SE0 bit times
                    dp_o <= 1'b0;
                    dm_o <= 1'b0;
                end
                2'd2: begin
                    level <= 1'b1;
                    dp_o  <= 1'b1;
                    dm_o  <= 1'b0;
                end
                default: begin
                    line_oe <= 1'b0;  // Hand the bus back after the J
                    dp_o    <= 1'b1;
                    dm_o    <= 1'b0;
                end
            endcase
        end else begin
            // Idle parks at J with the pad released
            level   <= 1'b1;
            eop_cnt <= 2'd0;
            dp_o    <= 1'b1;
            dm_o    <= 1'b0;
            line_oe <= 1'b0;
        end
    end

    // Serializer releases the link once the EOP is done
    a_release_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
        bits.eop_done |=> !bits.bit_active);

endmodule

/* source/utmi_tx_serializer.sv */
// UTMI transmit side: byte handshake, SYNC insertion, LSB-first serialisation and bit stuffing
`timescale 1ns/10ps

module utmi_tx_serializer (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [7:0]   data_out,
    input  logic         tx_valid,
    input  logic         suspend_m,
    input  logic [1:0]   op_mode,
    output logic         tx_ready,
    tx_bit_if.serializer bits
);

    // One-hot states
    localparam logic [3:0] ST_IDLE = 4'b0001;
    localparam logic [3:0] ST_SYNC = 4'b0010;
    localparam logic [3:0] ST_DATA = 4'b0100;
    localparam logic [3:0] ST_EOP  = 4'b1000;

    logic [3:0] state;
    logic [7:0] shift_reg;
    logic [2:0] bit_cnt;    // Bit position within the current byte
    logic [2:0] ones_cnt;   // Length of the current run of ones
    logic       draining;   // Packet over, one stuffed zero still owed
    logic       sending;
    logic       stuff_now;
    logic       start;
    logic       halt;

    assign sending   = state[1] | state[2];
    assign stuff_now = sending && (ones_cnt == 3'(usb_phy_pkg::STUFF_RUN));

    assign start = tx_valid && suspend_m && (op_mode == usb_phy_pkg::OPMODE_NORMAL);
    assign halt  = !suspend_m || (op_mode == usb_phy_pkg::OPMODE_NON_DRIVING);

    // Last bit of SYNC or of a data byte is going out this cycle
    assign tx_ready = sending && !stuff_now && (bit_cnt == 3'd7);

    assign bits.bit_active = !state[0];
    assign bits.bit_data   = sending && !stuff_now && shift_reg[0];
    assign bits.bit_eop    = state[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            bit_cnt  <= 3'd0;
            ones_cnt <= 3'd0;
            draining <= 1'b0;
        end else if (halt) begin
            state    <= ST_IDLE;  // Abandon any packet in flight
            draining <= 1'b0;
        end else begin
            case (1'b1)
                state[0]: begin
                    if (start) begin
                        state    <= ST_SYNC;
                        bit_cnt  <= 3'd0;
                        ones_cnt <= 3'd0;
                        draining <= 1'b0;
                    end
                end
                state[1], state[2]: begin
                    if (stuff_now) begin
                        ones_cnt <= 3'd0;  // Inserted zero, byte position holds
                        if (draining) begin
                            state    <= ST_EOP;
                            draining <= 1'b0;
                        end
                    end else begin
                        ones_cnt <= shift_reg[0] ? ones_cnt + 3'd1 : 3'd0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            if (tx_valid) begin
                                state <= ST_DATA;
                            end else if (shift_reg[0] &&
                                         ones_cnt == 3'(usb_phy_pkg::STUFF_RUN - 1)) begin
                                // Closing run of six ones needs its zero before EOP
                                draining <= 1'b1;
                            end else begin
                                state <= ST_EOP;
                            end
                        end
                    end
                end
                state[3]: begin
                    if (bits.eop_done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload shifter, preloaded with SYNC while idle
    always_ff @(posedge clk) begin
        if (state[0]) begin
            shift_reg <= usb_phy_pkg::SYNC_BYTE;
        end else if (sending && !stuff_now) begin
            if (bit_cnt == 3'd7)
                shift_reg <= data_out;  // Next byte taken on the tx_ready edge
            else
                shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // Every byte takes at least eight bit times
    a_tx_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_ready |=> !tx_ready);

endmodule

/* source/tx_bit_if.sv */
// Bit-level link from the transmit serializer to the NRZI line driver, one bit per clk
`timescale 1ns/10ps

interface tx_bit_if;

    logic bit_active;  // Packet in progress
    logic bit_data;    // Raw bit, already stuffed, not yet NRZI coded
    logic bit_eop;     // Send EOP instead of a data bit
    logic eop_done;    // Final J of the EOP is on the line

    modport serializer (
        output bit_active,
        output bit_data,
        output bit_eop,
        input  eop_done
    );

    modport driver (
        input  bit_active,
        input  bit_data,
        input  bit_eop,
        output eop_done
    );

endinterface

/* source/usb_phy_pkg.sv */
// Shared USB full-speed PHY definitions, referenced by scoped name from the RTL and testbench
package usb_phy_pkg;

    // Encoded as {dp, dm} straight from the synchronised pair
    typedef enum logic [1:0] {
        LS_SE0 = 2'b00,
        LS_K   = 2'b01,  // D- high
        LS_J   = 2'b10,  // D+ high, full-speed idle
        LS_SE1 = 2'b11   // Illegal on a healthy bus
    } line_state_e;

    // Ones in a row before a zero must be inserted
    localparam int STUFF_RUN = 6;

    // Sent LSB first, reads KJKJKJKK on the line
    localparam logic [7:0] SYNC_BYTE = 8'h80;

    // UTMI op_mode codes
    localparam logic [1:0] OPMODE_NORMAL      = 2'b00;
    localparam logic [1:0] OPMODE_NON_DRIVING = 2'b01;  // Transmitter held off

endpackage
